//--- hdl/board_pkg.sv
////////////////////
// Board glue package
// Reset, RTC and fan constants
// Meaningful widths and the SPI host and SD-card pin bundles
////////////////////

package board_pkg;

  ////////////////////
  // Reset synchronizer
  ////////////////////

  // Flops between the board reset and the SoC reset
  localparam int unsigned RstSyncStages = 2;

  ////////////////////
  // RTC divider
  ////////////////////

  // soc_clk cycles per RTC half period, divide-by-50 overall
  localparam int unsigned RtcHalfPeriod = 25;
  localparam int unsigned RtcCntWidth   = 5;

  ////////////////////
  // Fan PWM
  ////////////////////

  // Switch setting width, also the slot index width (16 slots)
  localparam int unsigned FanLevelWidth = 4;
  // soc_clk cycles per PWM slot, kept short for simulation
  localparam int unsigned FanPrescale   = 4;
  localparam int unsigned FanPrescWidth = 2;

  ////////////////////
  // Types
  ////////////////////

  // RTC half-period counter
  typedef logic [RtcCntWidth-1:0]   rtc_cnt_t;

  // Fan setting or PWM slot index
  typedef logic [FanLevelWidth-1:0] fan_level_t;

  // Outputs of the SoC SPI host
  typedef struct packed {
    logic       sck;
    logic       sck_en;
    logic [1:0] csb;
    logic [1:0] csb_en;
    logic [3:0] sd;
    logic [3:0] sd_en;
  } spi_host_t;

  // SD-card pins driven by the board in SPI mode
  typedef struct packed {
    logic       sclk;
    logic       cmd;
    logic       dat3;
    logic [1:0] dat21;
    logic       card_rst;
  } sd_pins_t;

endpackage

//--- hdl/board_rst_sync.sv
////////////////////
// Reset synchronizer for the SoC reset
// Asynchronous assertion, release on soc_clk
////////////////////

`timescale 1ns/100ps

module board_rst_sync
  import board_pkg::*;
(
  input  logic soc_clk,
  input  logic rst_n,
  output logic soc_rst_no
);

  // Shift chain, all stages low while the board reset is held
  logic [RstSyncStages-1:0] sync_q;

  ////////////////////
  // Synchronizer chain
  ////////////////////

  // Ones shift in from the bottom once rst_n is high again.
  // The last stage goes high RstSyncStages edges after release.
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[RstSyncStages-2:0], 1'b1};
    end
  end

  // Last stage is the SoC reset
  assign soc_rst_no = sync_q[RstSyncStages-1];

endmodule

//--- hdl/rtc_clk_div.sv
////////////////////
// RTC clock divider
// Toggles a registered clock every RtcHalfPeriod soc_clk cycles
////////////////////

`timescale 1ns/100ps

module rtc_clk_div
  import board_pkg::*;
(
  input  logic soc_clk,
  input  logic soc_rst_ni,
  output logic rtc_clk_o
);

  // Last count value of a half period
  localparam rtc_cnt_t CntLast = rtc_cnt_t'(RtcHalfPeriod - 1);

  rtc_cnt_t cnt_d;
  rtc_cnt_t cnt_q;
  logic     rtc_clk_d;
  logic     rtc_clk_q;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    cnt_d     = cnt_q + rtc_cnt_t'(1);
    rtc_clk_d = rtc_clk_q;

    // End of half period
    if (cnt_q == CntLast) begin
      cnt_d     = '0;
      rtc_clk_d = ~rtc_clk_q;
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  // Clock starts low, first toggle RtcHalfPeriod edges after release
  always_ff @(posedge soc_clk or negedge soc_rst_ni) begin
    if (!soc_rst_ni) begin
      cnt_q     <= '0;
      rtc_clk_q <= 1'b0;
    end else begin
      cnt_q     <= cnt_d;
      rtc_clk_q <= rtc_clk_d;
    end
  end

  // Straight from a flop, so no glitches
  assign rtc_clk_o = rtc_clk_q;

endmodule

//--- hdl/fan_pwm_ctrl.sv
////////////////////
// Fan PWM controller
// Prescaled slot counter, per-period setting latch, registered PWM
////////////////////

`timescale 1ns/100ps

module fan_pwm_ctrl
  import board_pkg::*;
(
  input  logic       soc_clk,
  input  logic       soc_rst_ni,
  input  fan_level_t fan_sw_i,
  output logic       fan_pwm_o
);

  // Last prescaler value and last slot of a period
  localparam logic [FanPrescWidth-1:0] PrescLast = FanPrescWidth'(FanPrescale - 1);
  localparam fan_level_t               SlotLast  = '1;

  logic [FanPrescWidth-1:0] presc_q;
  fan_level_t               slot_q;
  fan_level_t               level_q;
  logic                     pwm_q;

  // One pulse per slot
  logic slot_tick;
  // Slot counter wraps back to zero on this cycle
  logic period_wrap;

  assign slot_tick   = (presc_q == PrescLast);
  assign period_wrap = slot_tick && (slot_q == SlotLast);

  ////////////////////
  // Prescaler
  ////////////////////

  always_ff @(posedge soc_clk or negedge soc_rst_ni) begin
    if (!soc_rst_ni) begin
      presc_q <= '0;
    end else if (slot_tick) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + 1'b1;
    end
  end

  ////////////////////
  // Slot counter
  ////////////////////

  // Wraps naturally after the last slot
  always_ff @(posedge soc_clk or negedge soc_rst_ni) begin
    if (!soc_rst_ni) begin
      slot_q <= '0;
    end else if (slot_tick) begin
      slot_q <= slot_q + fan_level_t'(1);
    end
  end

  ////////////////////
  // Setting latch
  ////////////////////

  // Taken only at a period boundary so the duty is constant within a period
  always_ff @(posedge soc_clk or negedge soc_rst_ni) begin
    if (!soc_rst_ni) begin
      level_q <= '0;
    end else if (period_wrap) begin
      level_q <= fan_sw_i;
    end
  end

  ////////////////////
  // PWM output
  ////////////////////

  // High for level_q slots of FanPrescale cycles each
  always_ff @(posedge soc_clk or negedge soc_rst_ni) begin
    if (!soc_rst_ni) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= (slot_q < level_q);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

//--- hdl/board_glue_top.sv
////////////////////
// Board glue top level
// SoC reset, RTC clock, fan PWM and SD-card pins in SPI mode
////////////////////

`timescale 1ns/100ps

module board_glue_top
  import board_pkg::*;
(
  input  logic       soc_clk,
  input  logic       rst_n,

  // Board switches for the fan speed
  input  fan_level_t fan_sw_i,

  // SPI host side
  input  spi_host_t  spih_i,
  input  logic       sd_dat0_i,

  output logic       soc_rst_no,
  output logic       rtc_clk_o,
  output logic       fan_pwm_o,

  // SD-card side
  output sd_pins_t   sd_o,
  output logic [3:0] spih_sd_o
);

  ////////////////////
  // Reset synchronizer
  ////////////////////

  board_rst_sync u_rst_sync (
    .soc_clk    ( soc_clk    ),
    .rst_n      ( rst_n      ),
    .soc_rst_no ( soc_rst_no )
  );

  ////////////////////
  // RTC clock
  ////////////////////

  // Slow clock for the SoC real-time counter
  rtc_clk_div u_rtc_div (
    .soc_clk    ( soc_clk    ),
    .soc_rst_ni ( soc_rst_no ),
    .rtc_clk_o  ( rtc_clk_o  )
  );

  ////////////////////
  // Fan control
  ////////////////////

  fan_pwm_ctrl u_fan_ctrl (
    .soc_clk    ( soc_clk    ),
    .soc_rst_ni ( soc_rst_no ),
    .fan_sw_i   ( fan_sw_i   ),
    .fan_pwm_o  ( fan_pwm_o  )
  );

  ////////////////////
  // SD-card pin mapping
  ////////////////////

  // SPI lines idle high whenever the host does not drive them

  // SCK onto SD CLK
  assign sd_o.sclk     = spih_i.sck_en    ? spih_i.sck    : 1'b1;

  // First chip select onto SD DAT3
  assign sd_o.dat3     = spih_i.csb_en[0] ? spih_i.csb[0] : 1'b1;

  // MOSI onto SD CMD
  assign sd_o.cmd      = spih_i.sd_en[0]  ? spih_i.sd[0]  : 1'b1;

  // DAT1 and DAT2 unused in SPI mode
  assign sd_o.dat21    = 2'b11;

  // Reset held low so the card stays powered
  assign sd_o.card_rst = 1'b0;

  ////////////////////
  // Card data back to the host
  ////////////////////

  // MISO is host data bit 1, fed from SD DAT0
  assign spih_sd_o[1] = sd_dat0_i;

  // Remaining host inputs are outputs on this bus, read as zero
  assign spih_sd_o[0] = 1'b0;
  assign spih_sd_o[2] = 1'b0;
  assign spih_sd_o[3] = 1'b0;

endmodule

//--- dv/board_glue_assert.sv
////////////////////
// Concurrent checks for the RTC divider and the fan controller
// Bound into both peripherals
////////////////////

`timescale 1ns/100ps

module board_glue_assert
  import board_pkg::*;
(
  input  logic       soc_clk,
  input  logic       rst_ni,
  input  logic       is_rtc_i,
  input  logic       out_i,
  input  fan_level_t level_i,
  input  fan_level_t slot_i
);

  logic        out_q;
  int unsigned gap_q;

  // Failed assertions, summed up by the testbench
  int unsigned fail_cnt = 0;

  // Cycles since the output last changed
  always_ff @(posedge soc_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q <= 1'b0;
      gap_q <= 0;
    end else begin
      out_q <= out_i;
      gap_q <= (out_i != out_q) ? 0 : gap_q + 1;
    end
  end

  a_low_in_reset : assert property (@(posedge soc_clk) !rst_ni |-> !out_i)
    else begin
      fail_cnt++;
      $error("peripheral output high during reset");
    end

  a_rtc_half_period : assert property (@(posedge soc_clk) disable iff (!rst_ni || !is_rtc_i)
    $changed(out_i) |-> gap_q >= RtcHalfPeriod - 1)
    else begin
      fail_cnt++;
      $error("RTC clock toggled before a full half period");
    end

  // Slot counter went from the last slot back to zero
  a_latch_on_wrap : assert property (@(posedge soc_clk) disable iff (!rst_ni)
    $changed(level_i) |-> (slot_i == '0) && ($past(slot_i) == '1))
    else begin
      fail_cnt++;
      $error("fan setting latched away from a period wrap");
    end

endmodule

bind rtc_clk_div board_glue_assert u_rtc_assert (
  .soc_clk(soc_clk), .rst_ni(soc_rst_ni), .is_rtc_i(1'b1),
  .out_i(rtc_clk_o), .level_i('0), .slot_i('0)
);

bind fan_pwm_ctrl board_glue_assert u_fan_assert (
  .soc_clk(soc_clk), .rst_ni(soc_rst_ni), .is_rtc_i(1'b0),
  .out_i(fan_pwm_o), .level_i(level_q), .slot_i(slot_q)
);

//--- dv/tb_board_glue.sv
////////////////////
// Board glue testbench
// Reset, RTC, fan PWM and SD pin checks with a watchdog
////////////////////

`timescale 1ns/100ps

module tb_board_glue
  import board_pkg::*;
();

  localparam int ClkPeriod   = 10;
  localparam int ResetCycles = 10;
  localparam int FanPeriod   = FanPrescale << FanLevelWidth;
  localparam int NumDuty     = 10;
  localparam int NumSdVec    = 200;
  // Sum of all test lengths plus margin
  localparam int WatchdogCycles = ResetCycles + 9 * RtcHalfPeriod
    + NumDuty * 6 * FanPeriod + 8 * FanPeriod + NumSdVec + 500;

  logic       soc_clk;
  logic       rst_n;
  fan_level_t fan_sw;
  spi_host_t  spih;
  logic       sd_dat0;
  logic       soc_rst_n;
  logic       rtc_clk;
  logic       fan_pwm;
  sd_pins_t   sd_pins;
  logic [3:0] spih_sd;
  logic       sd_chk_en;
  int         err_cnt = 0;
  int         chk_cnt = 0;
  int         test_cnt = 0;
  int         test_err_start = 0;

  board_glue_top u_dut (
    .soc_clk(soc_clk), .rst_n(rst_n), .fan_sw_i(fan_sw), .spih_i(spih),
    .sd_dat0_i(sd_dat0), .soc_rst_no(soc_rst_n), .rtc_clk_o(rtc_clk),
    .fan_pwm_o(fan_pwm), .sd_o(sd_pins), .spih_sd_o(spih_sd)
  );

  initial begin
    soc_clk = 1'b0;
    forever #(ClkPeriod / 2) soc_clk = ~soc_clk;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("[FAIL] %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0s", test_cnt, name,
             (err_cnt == test_err_start) ? "ok" : "errors");
    test_err_start = err_cnt;
  endtask

  // Expected SD pins and host data, built from the pin rules
  function automatic logic [9:0] expected_pins(input spi_host_t host, input logic dat0);
    sd_pins_t   pins;
    logic [3:0] miso;
    pins.sclk     = host.sck_en    ? host.sck    : 1'b1;
    pins.dat3     = host.csb_en[0] ? host.csb[0] : 1'b1;
    pins.cmd      = host.sd_en[0]  ? host.sd[0]  : 1'b1;
    pins.dat21    = 2'b11;
    pins.card_rst = 1'b0;
    miso          = {2'b00, dat0, 1'b0};
    return {pins, miso};
  endfunction

  // Pin mapping compare, half a cycle after each new vector
  always @(negedge soc_clk) begin
    if (sd_chk_en) begin
      check_value({sd_pins, spih_sd}, expected_pins(spih, sd_dat0), "SD pin mapping");
    end
  end

  task automatic count_high(input int cycles, output int highs);
    highs = 0;
    repeat (cycles) begin
      @(negedge soc_clk);
      if (fan_pwm) highs++;
    end
  endtask

  // Apply a setting, let it settle for two periods, then count
  task automatic fan_high_count(input fan_level_t level, input int cycles, output int highs);
    @(posedge soc_clk);
    fan_sw <= level;
    repeat (2 * FanPeriod) @(posedge soc_clk);
    count_high(cycles, highs);
  endtask

  task automatic measure_gap(output int gap);
    logic start_level;
    start_level = rtc_clk;
    gap = 0;
    do begin
      @(negedge soc_clk);
      gap++;
    end while (rtc_clk == start_level && gap < 4 * RtcHalfPeriod);
  endtask

  initial begin
    logic [31:0] rnd;
    int          highs;
    fan_level_t  level;
    int          assert_errs;
    void'($urandom(32'hcbbb));
    rst_n     = 1'b0;
    fan_sw    = '0;
    spih      = '0;
    sd_dat0   = 1'b0;
    sd_chk_en = 1'b0;

    ////////////////////
    // Reset
    repeat (ResetCycles) begin
      @(negedge soc_clk);
      check_value({soc_rst_n, rtc_clk, fan_pwm}, 3'b000, "outputs during reset");
    end
    @(posedge soc_clk);
    rst_n <= 1'b1;
    @(negedge soc_clk);
    check_value(soc_rst_n, 1'b0, "SoC reset after release edge");
    @(negedge soc_clk);
    check_value(soc_rst_n, 1'b0, "SoC reset after one edge");
    @(negedge soc_clk);
    check_value(soc_rst_n, 1'b1, "SoC reset after two edges");
    end_test("reset");

    ////////////////////
    // RTC period, first rising edge then four full periods
    for (int i = 0; i < 9; i++) begin
      measure_gap(highs);
      check_value(highs, RtcHalfPeriod, "RTC half period");
      if (i == 0) check_value(rtc_clk, 1'b1, "first RTC edge is rising");
    end
    end_test("rtc period");

    ////////////////////
    // Fan duty over four periods
    for (int i = 0; i < NumDuty; i++) begin
      level = fan_level_t'($urandom_range(15, 0));
      fan_high_count(level, 4 * FanPeriod, highs);
      check_value(highs, 4 * level * FanPrescale, "fan high cycles");
    end
    end_test("fan duty");

    fan_high_count(fan_level_t'(0), 2 * FanPeriod, highs);
    check_value(highs, 0, "fan off high cycles");
    fan_high_count(fan_level_t'(15), FanPeriod, highs);
    check_value(highs, 15 * FanPrescale, "fan full first window");
    count_high(FanPeriod, highs);
    check_value(highs, 15 * FanPrescale, "fan full second window");
    end_test("fan extremes");

    ////////////////////
    // SD pin mapping
    for (int i = 0; i < NumSdVec; i++) begin
      rnd = $urandom;
      @(posedge soc_clk);
      spih      <= rnd[$bits(spi_host_t)-1:0];
      sd_dat0   <= rnd[31];
      sd_chk_en <= 1'b1;
    end
    @(posedge soc_clk);
    sd_chk_en <= 1'b0;
    @(negedge soc_clk);
    end_test("sd pin mapping");

    // Failures of the bound assertions count as errors too
    assert_errs = u_dut.u_rtc_div.u_rtc_assert.fail_cnt
                + u_dut.u_fan_ctrl.u_fan_assert.fail_cnt;
    if (assert_errs != 0) begin
      $display("Bound assertions failed %0d times", assert_errs);
      err_cnt += assert_errs;
    end

    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge soc_clk);
    $display("Watchdog timeout: the tests did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- board_glue_top.f
hdl/board_pkg.sv
hdl/board_rst_sync.sv
hdl/rtc_clk_div.sv
hdl/fan_pwm_ctrl.sv
hdl/board_glue_top.sv
dv/board_glue_assert.sv
dv/tb_board_glue.sv

//--- Makefile
# Verilator build and run for the board glue testbench

VERILATOR ?= verilator
TOP       ?= tb_board_glue
FLIST     ?= board_glue_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Output is shown and searched in one pass, no log file
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
